// File: dmix_pkg.sv
`default_nettype none

package dmix_pkg;

    // audio sources and samples
    localparam int NUM_SRC  = 2;
    localparam int SAMPLE_W = 24;               // signed
    localparam int VOL_W    = 16;               // unsigned, 32768 is unity
    localparam int VOL_SHIFT = 15;
    localparam logic [VOL_W-1:0] VOL_RESET = 16'h8000;
    localparam int NUM_VOL  = NUM_SRC * 2;      // one per source and side
    localparam int ACC_W    = 44;               // NUM_VOL products of 24x17 bits
    localparam int SRC_W    = (NUM_SRC > 1) ? $clog2(NUM_SRC) : 1;
    localparam int SEL_W    = SRC_W + 1;        // {source, side}

    // 48 kHz frame at 24.576 MHz
    localparam int FRAME_CLKS = 512;
    localparam int BCK_HALF   = 4;
    localparam int SLOT_BITS  = 32;
    localparam int FRAME_W    = $clog2(FRAME_CLKS);
    localparam int BIT_W      = $clog2(2 * BCK_HALF);

    // spi frame is wr flag, address, data
    localparam int SPI_FRAME_BITS = 24;
    localparam int SPI_ADDR_W     = 7;
    localparam int SPI_CMD_BITS   = SPI_FRAME_BITS - VOL_W;
    localparam int SPI_CNT_W      = $clog2(SPI_FRAME_BITS + 1);

endpackage

`default_nettype wire

// File: csr_spi.sv
`timescale 1ns/1ps
`default_nettype none

module csr_spi
    import dmix_pkg::*;
(
    input  logic                     clk245760,
    input  logic                     rst,
    input  logic                     spi_sck_i,
    input  logic                     spi_mosi_i,
    input  logic                     spi_ss_i,
    output logic                     spi_miso_o,
    output logic [NUM_VOL*VOL_W-1:0] vol_o
);

    logic [2:0]              sck_sr;    // two sync flops plus edge history
    logic [1:0]              mosi_sr;
    logic [1:0]              ss_sr;
    logic                    sck_rise;
    logic                    sck_fall;
    logic                    mosi_s;
    logic                    ss_s;
    logic [SPI_CNT_W-1:0]    bit_cnt;
    logic [VOL_W-1:0]        rx_sr;
    logic [VOL_W-1:0]        tx_sr;
    logic [SPI_ADDR_W-1:0]   addr_q;
    logic                    wr_q;
    logic [SPI_CMD_BITS-1:0] cmd;
    logic [VOL_W-1:0]        wdata;
    logic [VOL_W-1:0]        rd_data;
    logic [VOL_W-1:0]        vol_q [NUM_VOL];

    assign sck_rise = sck_sr[1] & ~sck_sr[2];
    assign sck_fall = ~sck_sr[1] & sck_sr[2];
    assign mosi_s   = mosi_sr[1];
    assign ss_s     = ss_sr[1];     // active low

    // incoming bit joined to what was shifted so far
    assign cmd   = {rx_sr[SPI_CMD_BITS-2:0], mosi_s};
    assign wdata = {rx_sr[VOL_W-2:0], mosi_s};

    always_ff @(posedge clk245760) begin
        if (rst) begin
            sck_sr  <= '0;
            mosi_sr <= '0;
            ss_sr   <= '1;
        end else begin
            sck_sr  <= {sck_sr[1:0], spi_sck_i};
            mosi_sr <= {mosi_sr[0], spi_mosi_i};
            ss_sr   <= {ss_sr[0], spi_ss_i};
        end
    end

    // read mux, out of range reads as zero
    always_comb begin
        rd_data = '0;
        for (int i = 0; i < NUM_VOL; i++) begin
            if (cmd[SPI_ADDR_W-1:0] == SPI_ADDR_W'(i))
                rd_data = vol_q[i];
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            bit_cnt    <= '0;
            spi_miso_o <= 1'b0;
            wr_q       <= 1'b0;
            addr_q     <= '0;
        end else if (ss_s) begin
            bit_cnt    <= '0;   // deselected, drop partial frame
            spi_miso_o <= 1'b0;
        end else begin
            if (sck_rise && bit_cnt != SPI_CNT_W'(SPI_FRAME_BITS)) begin
                rx_sr   <= wdata;
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == SPI_CNT_W'(SPI_CMD_BITS - 1)) begin
                    wr_q   <= cmd[SPI_CMD_BITS-1];
                    addr_q <= cmd[SPI_ADDR_W-1:0];
                    tx_sr  <= cmd[SPI_CMD_BITS-1] ? '0 : rd_data;
                end
            end
            // data phase, miso moves on falling sck
            if (sck_fall && bit_cnt >= SPI_CNT_W'(SPI_CMD_BITS)) begin
                spi_miso_o <= tx_sr[VOL_W-1];
                tx_sr      <= tx_sr << 1;
            end
        end
    end

    // write lands on the last rising edge of the frame
    always_ff @(posedge clk245760) begin
        if (rst) begin
            for (int i = 0; i < NUM_VOL; i++) begin
                vol_q[i] <= VOL_RESET;
            end
        end else if (!ss_s && sck_rise && wr_q &&
                     bit_cnt == SPI_CNT_W'(SPI_FRAME_BITS - 1)) begin
            for (int i = 0; i < NUM_VOL; i++) begin
                if (addr_q == SPI_ADDR_W'(i))
                    vol_q[i] <= wdata;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_VOL; i++) begin
            vol_o[i*VOL_W +: VOL_W] = vol_q[i];
        end
    end

endmodule

`default_nettype wire

// File: frame_timer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_timer
    import dmix_pkg::*;
(
    input  logic clk245760,
    input  logic rst,
    output logic bck_o,
    output logic lrck_o,
    output logic bit_stb_o,
    output logic frame_stb_o
);

    logic [FRAME_W-1:0] cnt;
    logic [BIT_W-1:0]   phase;  // clock within the current bit

    assign phase = cnt[BIT_W-1:0];

    // outputs registered from the count, one cycle behind it
    always_ff @(posedge clk245760) begin
        if (rst) begin
            cnt         <= '0;
            bck_o       <= 1'b0;
            lrck_o      <= 1'b0;
            bit_stb_o   <= 1'b0;
            frame_stb_o <= 1'b0;
        end else begin
            if (cnt == FRAME_W'(FRAME_CLKS - 1))
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;

            frame_stb_o <= (cnt == '0);
            bit_stb_o   <= (phase == '0);
            bck_o       <= (phase >= BIT_W'(BCK_HALF));   // high in second half
            lrck_o      <= cnt[FRAME_W-1];                // right slot is upper half
        end
    end

endmodule

`default_nettype wire

// File: mix_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mix_sequencer
    import dmix_pkg::*;
(
    input  logic             clk245760,
    input  logic             rst,
    input  logic             frame_stb_i,
    output logic             snap_o,
    output logic             clr_o,
    output logic             mac_o,
    output logic             store_o,
    output logic             side_o,
    output logic [SEL_W-1:0] sel_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_CLEAR,
        S_ACC,
        S_STORE
    } state_t;

    state_t           state;
    logic             side_q;   // 0 left, 1 right
    logic [SRC_W-1:0] src_idx;

    always_ff @(posedge clk245760) begin
        if (rst) begin
            state   <= S_IDLE;
            side_q  <= 1'b0;
            src_idx <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (frame_stb_i) begin
                        state  <= S_CLEAR;
                        side_q <= 1'b0;
                    end
                end
                S_CLEAR: begin
                    state   <= S_ACC;
                    src_idx <= '0;
                end
                S_ACC: begin
                    if (src_idx == SRC_W'(NUM_SRC - 1))
                        state <= S_STORE;
                    else
                        src_idx <= src_idx + 1'b1;
                end
                S_STORE: begin
                    if (side_q) begin
                        state <= S_IDLE;    // right done, run over
                    end else begin
                        side_q <= 1'b1;
                        state  <= S_CLEAR;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign snap_o  = (state == S_IDLE) && frame_stb_i;
    assign clr_o   = (state == S_CLEAR);
    assign mac_o   = (state == S_ACC);
    assign store_o = (state == S_STORE);
    assign side_o  = side_q;
    assign sel_o   = {src_idx, side_q};

endmodule

`default_nettype wire

// File: mix_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module mix_datapath
    import dmix_pkg::*;
(
    input  logic                        clk245760,
    input  logic                        rst,
    input  logic [NUM_SRC*SAMPLE_W-1:0] src_l_i,
    input  logic [NUM_SRC*SAMPLE_W-1:0] src_r_i,
    input  logic [NUM_SRC-1:0]          src_stb_i,
    input  logic [NUM_VOL*VOL_W-1:0]    vol_i,
    input  logic                        snap_i,
    input  logic                        clr_i,
    input  logic                        mac_i,
    input  logic                        store_i,
    input  logic                        side_i,
    input  logic [SEL_W-1:0]            sel_i,
    output logic [SAMPLE_W-1:0]         mix_l_o,
    output logic [SAMPLE_W-1:0]         mix_r_o
);

    logic signed [SAMPLE_W-1:0]      hold_l [NUM_SRC];
    logic signed [SAMPLE_W-1:0]      hold_r [NUM_SRC];
    logic signed [SAMPLE_W-1:0]      work_l [NUM_SRC];
    logic signed [SAMPLE_W-1:0]      work_r [NUM_SRC];
    logic        [VOL_W-1:0]         work_vol [NUM_VOL];
    logic signed [ACC_W-1:0]         acc;
    logic signed [ACC_W-1:0]         acc_sh;
    logic        [SRC_W-1:0]         src_sel;
    logic signed [SAMPLE_W-1:0]      mul_a;
    logic signed [VOL_W:0]           mul_b;
    logic signed [SAMPLE_W+VOL_W:0]  product;
    logic        [SAMPLE_W-1:0]      sat;

    // last strobed pair per source
    always_ff @(posedge clk245760) begin
        if (rst) begin
            for (int i = 0; i < NUM_SRC; i++) begin
                hold_l[i] <= '0;
                hold_r[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_SRC; i++) begin
                if (src_stb_i[i]) begin
                    hold_l[i] <= src_l_i[i*SAMPLE_W +: SAMPLE_W];
                    hold_r[i] <= src_r_i[i*SAMPLE_W +: SAMPLE_W];
                end
            end
        end
    end

    // working copies stay fixed for the whole run
    always_ff @(posedge clk245760) begin
        if (snap_i) begin
            for (int i = 0; i < NUM_SRC; i++) begin
                work_l[i] <= hold_l[i];
                work_r[i] <= hold_r[i];
            end
            for (int i = 0; i < NUM_VOL; i++) begin
                work_vol[i] <= vol_i[i*VOL_W +: VOL_W];
            end
        end
    end

    // one shared multiplier, volume zero-extended to signed
    assign src_sel = sel_i[SEL_W-1:1];
    assign mul_a   = side_i ? work_r[src_sel] : work_l[src_sel];
    assign mul_b   = $signed({1'b0, work_vol[sel_i]});
    assign product = mul_a * mul_b;

    always_ff @(posedge clk245760) begin
        if (clr_i)
            acc <= '0;
        else if (mac_i)
            acc <= acc + product;
    end

    assign acc_sh = acc >>> VOL_SHIFT;  // floor division

    // clamp when the upper bits are not all sign copies
    always_comb begin
        if (&acc_sh[ACC_W-1:SAMPLE_W-1] || ~|acc_sh[ACC_W-1:SAMPLE_W-1])
            sat = acc_sh[SAMPLE_W-1:0];
        else if (acc_sh[ACC_W-1])
            sat = {1'b1, {(SAMPLE_W-1){1'b0}}};
        else
            sat = {1'b0, {(SAMPLE_W-1){1'b1}}};
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            mix_l_o <= '0;
            mix_r_o <= '0;
        end else if (store_i) begin
            if (side_i)
                mix_r_o <= sat;
            else
                mix_l_o <= sat;
        end
    end

endmodule

`default_nettype wire

// File: i2s_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_serializer
    import dmix_pkg::*;
(
    input  logic                clk245760,
    input  logic                rst,
    input  logic                frame_stb_i,
    input  logic                bit_stb_i,
    input  logic [SAMPLE_W-1:0] mix_l_i,
    input  logic [SAMPLE_W-1:0] mix_r_i,
    output logic                dac_data_o
);

    logic [2*SLOT_BITS-1:0] shreg;
    logic [2*SLOT_BITS-1:0] word;
    logic                   held;   // bit shifted out one bit time ago

    // left slot then right slot, msb first, zero padded
    assign word = frame_stb_i ?
                  {mix_l_i, {(SLOT_BITS-SAMPLE_W){1'b0}},
                   mix_r_i, {(SLOT_BITS-SAMPLE_W){1'b0}}} :
                  shreg;

    always_ff @(posedge clk245760) begin
        if (rst) begin
            held       <= 1'b0;
            dac_data_o <= 1'b0;
        end else if (bit_stb_i) begin
            dac_data_o <= held;             // gives the one-bit i2s delay
            held       <= word[2*SLOT_BITS-1];
        end
    end

    always_ff @(posedge clk245760) begin
        if (bit_stb_i)
            shreg <= {word[2*SLOT_BITS-2:0], 1'b0};
    end

endmodule

`default_nettype wire

// File: dmix_top.sv
`timescale 1ns/1ps
`default_nettype none

module dmix_top
    import dmix_pkg::*;
(
    input  logic                        clk245760,
    input  logic                        rst,
    input  logic [NUM_SRC*SAMPLE_W-1:0] src_l_i,
    input  logic [NUM_SRC*SAMPLE_W-1:0] src_r_i,
    input  logic [NUM_SRC-1:0]          src_stb_i,
    input  logic                        spi_sck_i,
    input  logic                        spi_mosi_i,
    input  logic                        spi_ss_i,
    output logic                        spi_miso_o,
    output logic                        dac_bck_o,
    output logic                        dac_lrck_o,
    output logic                        dac_data_o
);

    logic [NUM_VOL*VOL_W-1:0] vol;
    logic                     bit_stb;
    logic                     frame_stb;
    logic                     snap;
    logic                     clr;
    logic                     mac;
    logic                     store;
    logic                     side;
    logic [SEL_W-1:0]         sel;
    logic [SAMPLE_W-1:0]      mix_l;
    logic [SAMPLE_W-1:0]      mix_r;

    csr_spi csr_spi_inst (
        .clk245760  (clk245760),
        .rst        (rst),
        .spi_sck_i  (spi_sck_i),
        .spi_mosi_i (spi_mosi_i),
        .spi_ss_i   (spi_ss_i),
        .spi_miso_o (spi_miso_o),
        .vol_o      (vol)
    );

    frame_timer frame_timer_inst (
        .clk245760   (clk245760),
        .rst         (rst),
        .bck_o       (dac_bck_o),
        .lrck_o      (dac_lrck_o),
        .bit_stb_o   (bit_stb),
        .frame_stb_o (frame_stb)
    );

    mix_sequencer mix_sequencer_inst (
        .clk245760   (clk245760),
        .rst         (rst),
        .frame_stb_i (frame_stb),
        .snap_o      (snap),
        .clr_o       (clr),
        .mac_o       (mac),
        .store_o     (store),
        .side_o      (side),
        .sel_o       (sel)
    );

    mix_datapath mix_datapath_inst (
        .clk245760 (clk245760),
        .rst       (rst),
        .src_l_i   (src_l_i),
        .src_r_i   (src_r_i),
        .src_stb_i (src_stb_i),
        .vol_i     (vol),
        .snap_i    (snap),
        .clr_i     (clr),
        .mac_i     (mac),
        .store_i   (store),
        .side_i    (side),
        .sel_i     (sel),
        .mix_l_o   (mix_l),
        .mix_r_o   (mix_r)
    );

    // mix of frame k goes out during frame k+1
    i2s_serializer i2s_serializer_inst (
        .clk245760   (clk245760),
        .rst         (rst),
        .frame_stb_i (frame_stb),
        .bit_stb_i   (bit_stb),
        .mix_l_i     (mix_l),
        .mix_r_i     (mix_r),
        .dac_data_o  (dac_data_o)
    );

endmodule

`default_nettype wire

// File: dmix_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dmix_tb
    import dmix_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int MAX_FRAMES = 64;
    localparam int FRAMES_RUN = 26;     // 8 + 12 + 6 frames of plain waiting
    localparam int SPI_XFERS  = 12;
    localparam int SPI_HALF   = 16;     // clocks per sck half period
    localparam int SPI_CLKS   = SPI_HALF * (2 * SPI_FRAME_BITS + 3);

    logic                        clk245760;
    logic                        rst;
    logic [NUM_SRC*SAMPLE_W-1:0] src_l;
    logic [NUM_SRC*SAMPLE_W-1:0] src_r;
    logic [NUM_SRC-1:0]          src_stb;
    logic                        spi_sck;
    logic                        spi_mosi;
    logic                        spi_ss;
    logic                        spi_miso;
    logic                        dac_bck;
    logic                        dac_lrck;
    logic                        dac_data;

    logic [31:0]                lfsr     = 32'h49497a9b;
    logic                       running  = 1'b0;
    logic                       stop     = 1'b0;
    logic                       spi_busy = 1'b0;
    logic signed [SAMPLE_W-1:0] hold_l_m [NUM_SRC];   // model of the holding registers
    logic signed [SAMPLE_W-1:0] hold_r_m [NUM_SRC];
    logic [VOL_W-1:0]           vol_m [NUM_VOL];
    logic [SAMPLE_W-1:0]        exp_l [MAX_FRAMES];
    logic [SAMPLE_W-1:0]        exp_r [MAX_FRAMES];
    logic                       exp_ok [MAX_FRAMES];
    logic [2*SLOT_BITS-1:0]     cap;
    int                         nbits   = 0;
    int                         fidx    = 0;
    int                         checked = 0;
    int                         pos_sat = 0;
    int                         neg_sat = 0;
    time                        last_fall;

    dmix_top dmix_top_inst (
        .clk245760  (clk245760),
        .rst        (rst),
        .src_l_i    (src_l),
        .src_r_i    (src_r),
        .src_stb_i  (src_stb),
        .spi_sck_i  (spi_sck),
        .spi_mosi_i (spi_mosi),
        .spi_ss_i   (spi_ss),
        .spi_miso_o (spi_miso),
        .dac_bck_o  (dac_bck),
        .dac_lrck_o (dac_lrck),
        .dac_data_o (dac_data)
    );

    initial begin
        clk245760 = 1'b0;
        forever #(CLK_PERIOD / 2) clk245760 = ~clk245760;
    end

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] want);
        $display("ERROR: %s got 0x%0h expected 0x%0h", name, got, want);
        stop_with_failure();
    endtask

    task automatic report_text(input string msg);
        $display("test failed, %s", msg);
        stop_with_failure();
    endtask

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // sum of sample times volume, floor shift, clamp to 24 bits
    function automatic logic [SAMPLE_W-1:0] mix_side(input int side);
        longint acc;
        acc = 0;
        for (int s = 0; s < NUM_SRC; s++) begin
            acc = acc + longint'(side ? hold_r_m[s] : hold_l_m[s]) *
                        longint'(vol_m[2*s+side]);
        end
        acc = acc >>> VOL_SHIFT;
        if (acc > 8388607)
            return 24'h7fffff;
        else if (acc < -8388608)
            return 24'h800000;
        return acc[SAMPLE_W-1:0];
    endfunction

    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk245760);
        #5;
    endtask

    // one mode 0 frame, miso taken just before each rising sck
    task automatic spi_xfer(input logic wr, input logic [SPI_ADDR_W-1:0] addr,
                            input logic [VOL_W-1:0] wdata, output logic [VOL_W-1:0] rdata);
        logic [SPI_FRAME_BITS-1:0] frame;
        spi_busy = 1'b1;
        frame    = {wr, addr, wdata};
        rdata    = '0;
        spi_ss   = 1'b0;
        wait_clks(SPI_HALF);
        for (int b = 0; b < SPI_FRAME_BITS; b++) begin
            spi_mosi = frame[SPI_FRAME_BITS-1-b];
            wait_clks(SPI_HALF);
            if (b >= SPI_FRAME_BITS - VOL_W)
                rdata = {rdata[VOL_W-2:0], spi_miso};
            spi_sck = 1'b1;
            wait_clks(SPI_HALF);
            spi_sck = 1'b0;
        end
        wait_clks(SPI_HALF);
        spi_ss = 1'b1;
        wait_clks(SPI_HALF);
        if (wr && addr < NUM_VOL)
            vol_m[addr] = wdata;
        spi_busy = 1'b0;
    endtask

    // random strobes, about one in 64 cycles per source
    initial begin : source_driver
        int c;
        wait (running);
        c = 0;
        while (!stop) begin
            for (int s = 0; s < NUM_SRC; s++) begin
                src_stb[s] = (lfsr_bits(6) == 0);
                if (src_stb[s]) begin
                    src_l[s*SAMPLE_W +: SAMPLE_W] = lfsr_bits(SAMPLE_W);
                    src_r[s*SAMPLE_W +: SAMPLE_W] = lfsr_bits(SAMPLE_W);
                    hold_l_m[s] = src_l[s*SAMPLE_W +: SAMPLE_W];
                    hold_r_m[s] = src_r[s*SAMPLE_W +: SAMPLE_W];
                end
            end
            // last drive that the next snapshot still sees
            if (c % FRAME_CLKS == 0 && c / FRAME_CLKS < MAX_FRAMES) begin
                exp_l[c/FRAME_CLKS]  = mix_side(0);
                exp_r[c/FRAME_CLKS]  = mix_side(1);
                exp_ok[c/FRAME_CLKS] = !spi_busy;    // volume may be in flight
            end
            wait_clks(1);
            c++;
        end
    end

    always @(posedge dac_bck) begin
        assert (dac_lrck == (nbits >= SLOT_BITS))
            else report_value("dac_lrck_o", dac_lrck, nbits >= SLOT_BITS);
        cap   = {cap[2*SLOT_BITS-2:0], dac_data};
        nbits = nbits + 1;
    end

    // falling lrck closes the previous frame
    always @(negedge dac_lrck) begin : frame_check
        logic [SAMPLE_W-1:0] el;
        logic [SAMPLE_W-1:0] er;
        if (running) begin
            if (fidx > 0) begin
                assert ($time - last_fall == FRAME_CLKS * CLK_PERIOD)
                    else report_text("word clock period is not 512 clocks");
            end
            assert (nbits == 2 * SLOT_BITS)
                else report_text("a frame does not hold 64 bit clocks");
            assert ({cap[63], cap[38:31], cap[6:0]} == '0)
                else report_value("dac_data_o pad bits", {cap[63], cap[38:31], cap[6:0]}, 0);
            if (fidx == 0 || exp_ok[fidx-1]) begin
                el = (fidx == 0) ? '0 : exp_l[fidx-1];
                er = (fidx == 0) ? '0 : exp_r[fidx-1];
                assert (cap[62:39] == el) else report_value("dac_data_o left", cap[62:39], el);
                assert (cap[30:7] == er) else report_value("dac_data_o right", cap[30:7], er);
                checked++;
                if (el == 24'h7fffff || er == 24'h7fffff)
                    pos_sat++;
                if (el == 24'h800000 || er == 24'h800000)
                    neg_sat++;
            end
            fidx++;
            last_fall = $time;
        end
        nbits = 0;
    end

    initial begin
        #((FRAMES_RUN + 4) * FRAME_CLKS * CLK_PERIOD + SPI_XFERS * SPI_CLKS * CLK_PERIOD);
        report_text("timeout, the test sequence did not finish in time");
    end

    initial begin : main_flow
        logic [VOL_W-1:0]      vol_rand [NUM_VOL];
        logic [VOL_W-1:0]      rd;
        logic [SPI_ADDR_W-1:0] bad_addr;
        rst      = 1'b1;
        src_l    = '0;
        src_r    = '0;
        src_stb  = '0;
        spi_sck  = 1'b0;
        spi_mosi = 1'b0;
        spi_ss   = 1'b1;
        for (int i = 0; i < NUM_SRC; i++) begin
            hold_l_m[i] = '0;
            hold_r_m[i] = '0;
        end
        for (int i = 0; i < NUM_VOL; i++) begin
            vol_m[i]    = VOL_RESET;
            vol_rand[i] = lfsr_bits(VOL_W);
        end
        bad_addr = NUM_VOL + lfsr_bits(SPI_ADDR_W) % (2**SPI_ADDR_W - NUM_VOL);
        repeat (16) @(posedge clk245760);
        #5;
        rst     = 1'b0;
        running = 1'b1;
        wait_clks(8 * FRAME_CLKS);      // unity gain

        for (int i = 0; i < NUM_VOL; i++)
            spi_xfer(1'b1, SPI_ADDR_W'(i), vol_rand[i], rd);
        spi_xfer(1'b1, bad_addr, 16'hffff, rd);
        spi_xfer(1'b0, bad_addr, '0, rd);
        assert (rd == '0) else report_value("spi_miso_o", rd, 0);
        for (int i = 0; i < NUM_VOL; i++) begin
            spi_xfer(1'b0, SPI_ADDR_W'(i), '0, rd);
            assert (rd == vol_rand[i]) else report_value("spi_miso_o", rd, vol_rand[i]);
        end
        wait_clks(12 * FRAME_CLKS);     // random gains, saturation

        spi_xfer(1'b1, 7'd2, '0, rd);   // mute source 1
        spi_xfer(1'b1, 7'd3, '0, rd);
        wait_clks(6 * FRAME_CLKS);

        assert (checked >= 16) else report_text("too few frames were compared");
        assert (pos_sat > 0 && neg_sat > 0)
            else report_text("saturation was not reached in both directions");
        stop = 1'b1;
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
dmix_pkg.sv
csr_spi.sv
frame_timer.sv
mix_sequencer.sv
mix_datapath.sv
i2s_serializer.sv
dmix_top.sv
dmix_tb.sv
